// File: pcmAudioPkg.sv
/*
 * shared constants of the mono PCM sound device
 * address map, register offsets, control bits, rate table, output levels
 */
`default_nettype none

package pcmAudioPkg;

	// address bits 27:16 that select the device
	localparam logic [11:0] DeviceSelect = 12'h009;
	// address bits 15:12 for the register window
	localparam logic [3:0] ControlWindow = 4'hF;
	// address bits 15:14 for sample memory
	localparam logic [1:0] SampleWindow = 2'h0;

	// word offsets taken from address bits 7:2
	localparam logic [5:0] RegControl = 6'h00;
	localparam logic [5:0] RegBeep = 6'h01;
	localparam logic [5:0] RegPosition = 6'h08;

	// control register layout
	localparam int UseCompandBit = 0;
	localparam int Use16BitBit = 1;
	localparam int OutEnableBit = 3;
	localparam int RateFieldLow = 4;
	localparam int RateFieldHigh = 7;

	// divider reloads for a 50 MHz clock, indexed by the rate field
	// entry 8 and above mostly fall back to the fastest rate
	localparam logic [13:0] RateDivTable [16] = '{
		14'd6250, 14'd4535, 14'd3125, 14'd2268,
		14'd1562, 14'd1134, 14'd781, 14'd567,
		14'd390, 14'd1042, 14'd390, 14'd521,
		14'd390, 14'd390, 14'd390, 14'd390
	};

	// square wave levels that replace the sample while beeping
	localparam logic [15:0] BeepHigh = 16'h0FFF;
	localparam logic [15:0] BeepLow = 16'hF000;

	// signed sample level and modulator accumulator widths
	localparam int LevelWidth = 16;
	localparam int PwmWidth = 16;

endpackage

`default_nettype wire

// File: pcmBusRegs.sv
/*
 * bus slave of the sound device with control and beeper registers
 * acknowledges two cycles after a strobe and forwards sample writes to memory
 */
`timescale 1ns/1ps
`default_nettype none

module pcmBusRegs #(
	parameter int MemBlocks = 1024,
	localparam int PosWidth = $clog2(MemBlocks) + 3,
	localparam int IdxWidth = $clog2(MemBlocks)
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic [31:0] busAddr,
	input wire logic [31:0] busWriteData,
	input wire logic busRead,
	input wire logic busWrite,
	input wire logic [PosWidth-1:0] samplePos,
	output logic [31:0] busReadData,
	output logic busOk,
	output logic memWrite,
	output logic [IdxWidth:0] memWordAddr,
	output logic [31:0] memWriteData,
	output logic useCompand,
	output logic use16Bit,
	output logic outEnable,
	output logic [3:0] rateSelect,
	output logic [15:0] beepDivider
);

	// registered request
	logic [31:0] reqAddr;
	logic [31:0] reqWriteData;
	logic reqRead;
	logic reqWrite;

	logic devHit;
	logic ctrlHit;
	logic sampleHit;
	logic [5:0] regOffset;
	logic [31:0] readNext;

	logic [31:0] ctrlReg;
	logic [31:0] beepReg;

	// request captured one cycle after the strobe
	always_ff @(posedge clock)
	begin
		reqAddr <= busAddr;
		reqWriteData <= busWriteData;
		if (reset)
		begin
			reqRead <= 1'b0;
			reqWrite <= 1'b0;
		end
		else
		begin
			reqRead <= busRead;
			reqWrite <= busWrite;
		end
	end

	// window decode
	assign devHit = (reqAddr[27:16] == pcmAudioPkg::DeviceSelect);
	assign ctrlHit = (reqAddr[15:12] == pcmAudioPkg::ControlWindow);
	assign sampleHit = (reqAddr[15:14] == pcmAudioPkg::SampleWindow);
	assign regOffset = reqAddr[7:2];

	// sample memory write port
	// bit 2 of the byte address picks the bank
	assign memWrite = reqWrite && devHit && sampleHit;
	assign memWordAddr = reqAddr[IdxWidth+2:2];
	assign memWriteData = reqWriteData;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			ctrlReg <= '0;
			beepReg <= '0;
		end
		else if (reqWrite && devHit && ctrlHit)
		begin
			case (regOffset)
				pcmAudioPkg::RegControl: ctrlReg <= reqWriteData;
				pcmAudioPkg::RegBeep: beepReg <= reqWriteData;
				default:
				begin
				end
			endcase
		end
	end

	// unmapped offsets read as zero
	always_comb
	begin
		readNext = '0;
		if (reqRead && devHit && ctrlHit)
		begin
			case (regOffset)
				pcmAudioPkg::RegControl: readNext = ctrlReg;
				pcmAudioPkg::RegBeep: readNext = beepReg;
				pcmAudioPkg::RegPosition: readNext = 32'(samplePos);
				default: readNext = '0;
			endcase
		end
	end

	// second stage of the fixed two-cycle response
	always_ff @(posedge clock)
	begin
		busReadData <= readNext;
		if (reset)
			busOk <= 1'b0;
		else
			busOk <= devHit && (reqRead || reqWrite);
	end

	// control fields
	assign useCompand = ctrlReg[pcmAudioPkg::UseCompandBit];
	assign use16Bit = ctrlReg[pcmAudioPkg::Use16BitBit];
	assign outEnable = ctrlReg[pcmAudioPkg::OutEnableBit];
	assign rateSelect = ctrlReg[pcmAudioPkg::RateFieldHigh:pcmAudioPkg::RateFieldLow];
	assign beepDivider = beepReg[15:0];

	// every acknowledge belongs to a strobe two cycles back
	ackFollowsStrobe: assert property (@(posedge clock) disable iff (reset)
		busOk |-> $past(busRead || busWrite, 2));

	// master issues one kind of request at a time
	noReadWriteOverlap: assert property (@(posedge clock) disable iff (reset)
		!(busRead && busWrite));

endmodule

`default_nettype wire

// File: pcmSampleClock.sv
/*
 * sample rate divider and playback position counter
 * reload comes from the rate table, position wraps over the whole memory
 */
`timescale 1ns/1ps
`default_nettype none

module pcmSampleClock #(
	parameter int MemBlocks = 1024,
	localparam int PosWidth = $clog2(MemBlocks) + 3
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic [3:0] rateSelect,
	output logic [PosWidth-1:0] samplePos
);

	logic [13:0] divCount;
	logic [13:0] divReload;

	// table lookup registered, one cycle behind the rate field
	always_ff @(posedge clock)
	begin
		if (reset)
			divReload <= '0;
		else
			divReload <= pcmAudioPkg::RateDivTable[rateSelect];
	end

	// count down, step position on each reload
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			divCount <= '0;
			samplePos <= '0;
		end
		else if (divCount == '0)
		begin
			divCount <= divReload;
			samplePos <= samplePos + 1'b1;
		end
		else
		begin
			divCount <= divCount - 1'b1;
		end
	end

	// position only ever moves forward by one
	posStepsByOne: assert property (@(posedge clock) disable iff (reset)
		(samplePos != $past(samplePos)) |->
		(samplePos == PosWidth'($past(samplePos) + 1'b1)));

endmodule

`default_nettype wire

// File: pcmSampleMem.sv
/*
 * sample memory as two 32-bit banks forming 64-bit blocks
 * bus side writes words, playback side reads a block and picks one sample
 */
`timescale 1ns/1ps
`default_nettype none

module pcmSampleMem #(
	parameter int MemBlocks = 1024,
	localparam int PosWidth = $clog2(MemBlocks) + 3,
	localparam int IdxWidth = $clog2(MemBlocks)
) (
	input wire logic clock,
	input wire logic memWrite,
	input wire logic [IdxWidth:0] memWordAddr,
	input wire logic [31:0] memWriteData,
	input wire logic [PosWidth-1:0] samplePos,
	input wire logic use16Bit,
	output logic [15:0] rawSample
);

	// low bank holds bytes 3:0 of a block, high bank bytes 7:4
	logic [31:0] memLow [MemBlocks];
	logic [31:0] memHigh [MemBlocks];

	logic [IdxWidth-1:0] readIndex;
	logic [63:0] block;
	logic [2:0] pickPos;
	logic pick16Bit;

	always_ff @(posedge clock)
	begin
		if (memWrite)
		begin
			if (memWordAddr[0])
				memHigh[memWordAddr[IdxWidth:1]] <= memWriteData;
			else
				memLow[memWordAddr[IdxWidth:1]] <= memWriteData;
		end
	end

	// four halfwords or eight bytes per block
	assign readIndex = use16Bit ? samplePos[IdxWidth+1:2] : samplePos[IdxWidth+2:3];

	// block read, keep position bits and format aligned with it
	always_ff @(posedge clock)
	begin
		block <= {memHigh[readIndex], memLow[readIndex]};
		pickPos <= samplePos[2:0];
		pick16Bit <= use16Bit;
	end

	// sample pick
	always_ff @(posedge clock)
	begin
		if (pick16Bit)
			rawSample <= block[pickPos[1:0]*16 +: 16];
		else
			rawSample <= {8'h00, block[pickPos*8 +: 8]};
	end

endmodule

`default_nettype wire

// File: pcmDecode.sv
/*
 * expands a raw sample into a signed 16-bit level
 * handles 8-bit offset binary, 8-bit companded and 16-bit samples
 */
`timescale 1ns/1ps
`default_nettype none

module pcmDecode (
	input wire logic clock,
	input wire logic [15:0] rawSample,
	input wire logic useCompand,
	input wire logic use16Bit,
	output logic signed [pcmAudioPkg::LevelWidth-1:0] level
);

	logic sign;
	logic [2:0] exponent;
	logic [3:0] mantissa;
	logic [10:0] magnitude;
	logic [11:0] compandValue;
	logic [11:0] compandReg;
	logic [11:0] value12;

	// companded byte is sign, exponent, mantissa
	assign sign = rawSample[7];
	assign exponent = rawSample[6:4];
	assign mantissa = rawSample[3:0];

	// exponent zero is denormal, otherwise hidden one above the mantissa
	always_comb
	begin
		if (exponent == 3'd0)
			magnitude = {7'd0, mantissa};
		else
			magnitude = 11'({1'b1, mantissa}) << (exponent - 3'd1);
	end

	// negative values get the complemented magnitude
	assign compandValue = sign ? {1'b1, ~magnitude} : {1'b0, magnitude};

	// extra stage on the companded path only
	always_ff @(posedge clock)
	begin
		compandReg <= compandValue;
	end

	// offset binary to two's complement by flipping the top bit
	always_comb
	begin
		if (use16Bit)
			value12 = {~rawSample[15], rawSample[14:4]};
		else if (useCompand)
			value12 = compandReg;
		else
			value12 = {~rawSample[7], rawSample[6:0], 4'h0};
	end

	// repeat the top nibble so full scale reaches the low bits
	always_ff @(posedge clock)
	begin
		level <= {value12, value12[11:8]};
	end

endmodule

`default_nettype wire

// File: pcmBeeper.sv
/*
 * square wave beeper clocked by an external 1 MHz tick
 * active while the divider register is nonzero
 */
`timescale 1ns/1ps
`default_nettype none

module pcmBeeper (
	input wire logic clock,
	input wire logic reset,
	input wire logic tick1Mhz,
	input wire logic [15:0] beepDivider,
	output logic beepActive,
	output logic beepBit
);

	logic [15:0] dividerStage;
	logic [15:0] reloadValue;
	logic [15:0] count;

	// two stages between register and counter
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			dividerStage <= '0;
			reloadValue <= '0;
		end
		else
		begin
			dividerStage <= beepDivider;
			reloadValue <= dividerStage;
		end
	end

	assign beepActive = (reloadValue != '0);

	// half period is reload plus one ticks
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			count <= '0;
			beepBit <= 1'b0;
		end
		else if (count == '0)
		begin
			count <= reloadValue;
			beepBit <= ~beepBit;
		end
		else if (tick1Mhz)
		begin
			count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: pcmOutputStage.sv
/*
 * output stage: scales the level, mixes in the beeper, clips
 * and drives a first-order delta-sigma PWM bit
 */
`timescale 1ns/1ps
`default_nettype none

module pcmOutputStage (
	input wire logic clock,
	input wire logic reset,
	input wire logic signed [pcmAudioPkg::LevelWidth-1:0] level,
	input wire logic outEnable,
	input wire logic beepActive,
	input wire logic beepBit,
	output logic pwmOut,
	output logic pwmEnable
);

	logic [15:0] mixedNext;
	logic [15:0] mixed;
	logic [pcmAudioPkg::PwmWidth-1:0] clipNext;
	logic [pcmAudioPkg::PwmWidth-1:0] clipped;
	logic [pcmAudioPkg::PwmWidth-1:0] accum;
	logic [pcmAudioPkg::PwmWidth-1:0] accumNext;
	logic carry;

	// quarter level for headroom, beeper overrides the sample
	always_comb
	begin
		if (beepActive)
			mixedNext = beepBit ? pcmAudioPkg::BeepHigh : pcmAudioPkg::BeepLow;
		else
			mixedNext = 16'(level >>> 2);
	end

	// signed value to unsigned duty, saturate outside 14-bit range
	always_comb
	begin
		case (mixed[15:13])
			3'b000: clipNext = {1'b1, mixed[12:0], 2'b00};
			3'b111: clipNext = {1'b0, mixed[12:0], 2'b00};
			3'b001, 3'b010, 3'b011: clipNext = 16'hFFFF;
			default: clipNext = 16'h0000;
		endcase
	end

	always_ff @(posedge clock)
	begin
		mixed <= mixedNext;
		clipped <= clipNext;
	end

	// carry out of the accumulator is the PWM density
	assign {carry, accumNext} = {1'b0, accum} + {1'b0, clipped};

	// modulator idles at zero while output is off
	always_ff @(posedge clock)
	begin
		if (reset || !outEnable)
			accum <= '0;
		else
			accum <= accumNext;
	end

	// line idles high when disabled
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pwmOut <= 1'b1;
			pwmEnable <= 1'b0;
		end
		else
		begin
			pwmOut <= outEnable ? carry : 1'b1;
			pwmEnable <= outEnable;
		end
	end

	disabledOutHigh: assert property (@(posedge clock) disable iff (reset)
		!pwmEnable |-> pwmOut);

endmodule

`default_nettype wire

// File: pcmAudio.sv
/*
 * top of the mono PCM sound device
 * connects bus slave, sample clock, memory, decoder, beeper and output stage
 */
`timescale 1ns/1ps
`default_nettype none

module pcmAudio #(
	parameter int MemBlocks = 1024,
	localparam int PosWidth = $clog2(MemBlocks) + 3,
	localparam int IdxWidth = $clog2(MemBlocks)
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic [31:0] busAddr,
	input wire logic [31:0] busWriteData,
	input wire logic busRead,
	input wire logic busWrite,
	input wire logic tick1Mhz,
	output logic [31:0] busReadData,
	output logic busOk,
	output logic pwmOut,
	output logic pwmEnable
);

	// memory write path
	logic memWrite;
	logic [IdxWidth:0] memWordAddr;
	logic [31:0] memWriteData;

	// control fields
	logic useCompand;
	logic use16Bit;
	logic outEnable;
	logic [3:0] rateSelect;
	logic [15:0] beepDivider;

	// playback path
	logic [PosWidth-1:0] samplePos;
	logic [15:0] rawSample;
	logic signed [pcmAudioPkg::LevelWidth-1:0] level;
	logic beepActive;
	logic beepBit;

	pcmBusRegs #(
		.MemBlocks(MemBlocks)
	) i_pcmBusRegs (
		.clock(clock),
		.reset(reset),
		.busAddr(busAddr),
		.busWriteData(busWriteData),
		.busRead(busRead),
		.busWrite(busWrite),
		.samplePos(samplePos),
		.busReadData(busReadData),
		.busOk(busOk),
		.memWrite(memWrite),
		.memWordAddr(memWordAddr),
		.memWriteData(memWriteData),
		.useCompand(useCompand),
		.use16Bit(use16Bit),
		.outEnable(outEnable),
		.rateSelect(rateSelect),
		.beepDivider(beepDivider)
	);

	pcmSampleClock #(
		.MemBlocks(MemBlocks)
	) i_pcmSampleClock (
		.clock(clock),
		.reset(reset),
		.rateSelect(rateSelect),
		.samplePos(samplePos)
	);

	pcmSampleMem #(
		.MemBlocks(MemBlocks)
	) i_pcmSampleMem (
		.clock(clock),
		.memWrite(memWrite),
		.memWordAddr(memWordAddr),
		.memWriteData(memWriteData),
		.samplePos(samplePos),
		.use16Bit(use16Bit),
		.rawSample(rawSample)
	);

	pcmDecode i_pcmDecode (
		.clock(clock),
		.rawSample(rawSample),
		.useCompand(useCompand),
		.use16Bit(use16Bit),
		.level(level)
	);

	pcmBeeper i_pcmBeeper (
		.clock(clock),
		.reset(reset),
		.tick1Mhz(tick1Mhz),
		.beepDivider(beepDivider),
		.beepActive(beepActive),
		.beepBit(beepBit)
	);

	pcmOutputStage i_pcmOutputStage (
		.clock(clock),
		.reset(reset),
		.level(level),
		.outEnable(outEnable),
		.beepActive(beepActive),
		.beepBit(beepBit),
		.pwmOut(pwmOut),
		.pwmEnable(pwmEnable)
	);

endmodule

`default_nettype wire

// File: pcmAudioTb.sv
/*
 * testbench that drives the bus and the 1 MHz tick of the mono PCM sound device
 * checks registers, position rate, PWM density per format and the beeper
 */
`timescale 1ns/1ps
`default_nettype none

module pcmAudioTb;

	// sizes of the default build
	localparam int MemBlocks = 1024;
	localparam int MemWords = 2 * MemBlocks;
	localparam int PosWidth = $clog2(MemBlocks) + 3;
	localparam int AckTimeout = 8;
	localparam int WatchdogCycles = 1000000;

	// control words
	localparam logic [31:0] Rate8 = 32'(8) << pcmAudioPkg::RateFieldLow;
	localparam logic [31:0] OutOn = 32'(1) << pcmAudioPkg::OutEnableBit;
	localparam logic [31:0] Fmt16 = 32'(1) << pcmAudioPkg::Use16BitBit;
	localparam logic [31:0] Compand = 32'(1) << pcmAudioPkg::UseCompandBit;

	logic clock;
	logic reset;
	logic [31:0] busAddr;
	logic [31:0] busWriteData;
	logic busRead;
	logic busWrite;
	logic tick1Mhz;
	logic [31:0] busReadData;
	logic busOk;
	logic pwmOut;
	logic pwmEnable;

	integer seed = 67;
	int errorCount = 0;
	int errorsAtStart = 0;
	int testCount = 0;
	int failedTests = 0;
	logic [15:0] sample16;

	pcmAudio i_pcmAudio (
		.clock(clock),
		.reset(reset),
		.busAddr(busAddr),
		.busWriteData(busWriteData),
		.busRead(busRead),
		.busWrite(busWrite),
		.tick1Mhz(tick1Mhz),
		.busReadData(busReadData),
		.busOk(busOk),
		.pwmOut(pwmOut),
		.pwmEnable(pwmEnable)
	);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// acknowledge only ever answers a strobe two cycles back
	ackOnlyAfterRequest: assert property (@(posedge clock) disable iff (reset)
		busOk |-> $past(busRead || busWrite, 2))
	else
	begin
		$display("acknowledge raised without a request two cycles earlier");
		errorCount++;
	end

	// line idles high while output is off
	idleLineHigh: assert property (@(posedge clock) disable iff (reset)
		!pwmEnable |-> pwmOut)
	else
	begin
		$display("Mismatch pwmOut: got %h, expected 1 while disabled", $sampled(pwmOut));
		errorCount++;
	end

	function automatic logic [31:0] regAddr(input logic [5:0] offset);
		return {4'h0, pcmAudioPkg::DeviceSelect, pcmAudioPkg::ControlWindow, 4'h0,
			offset, 2'b00};
	endfunction

	function automatic logic [31:0] sampleAddr(input int word);
		return {4'h0, pcmAudioPkg::DeviceSelect, pcmAudioPkg::SampleWindow, 14'(word * 4)};
	endfunction

	// sign, exponent, mantissa expanded to 12 bits
	function automatic logic [11:0] decodeCompanded(input logic [7:0] code);
		int exponent;
		int magnitude;
		exponent = code[6:4];
		if (exponent == 0)
			magnitude = code[3:0];
		else
			magnitude = (16 + code[3:0]) << (exponent - 1);
		if (code[7])
			return {1'b1, ~magnitude[10:0]};
		else
			return {1'b0, magnitude[10:0]};
	endfunction

	function automatic logic [15:0] levelFrom12(input logic [11:0] value);
		return {value, value[11:8]};
	endfunction

	// top three bits pick pass-through or saturation
	function automatic logic [15:0] clipMixed(input logic [15:0] mixed);
		case (mixed[15:13])
			3'b000: return {1'b1, mixed[12:0], 2'b00};
			3'b111: return {1'b0, mixed[12:0], 2'b00};
			default: return mixed[15] ? 16'h0000 : 16'hFFFF;
		endcase
	endfunction

	function automatic logic [15:0] dutyForLevel(input logic [15:0] level);
		logic signed [15:0] scaled;
		scaled = $signed(level) >>> 2;
		return clipMixed(scaled);
	endfunction

	task automatic checkEqual(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got === expected)
		else
		begin
			$display("Mismatch %s: got %h, expected %h", name, got, expected);
			errorCount++;
		end
	endtask

	task automatic checkNear(input string name, input int got, input int expected,
		input int tolerance);
		int diff;
		diff = got - expected;
		assert (diff <= tolerance && diff >= -tolerance)
		else
		begin
			$display("Mismatch %s: got %h, expected %h within %0d", name, got, expected,
				tolerance);
			errorCount++;
		end
	endtask

	// one strobe and a bounded wait for the acknowledge
	task automatic busAccess(input logic write, input logic [31:0] addr,
		input logic [31:0] writeData, output logic [31:0] readData, output logic acked);
		int latency;
		@(posedge clock);
		busAddr <= addr;
		busWriteData <= writeData;
		busRead <= !write;
		busWrite <= write;
		@(posedge clock);
		busRead <= 1'b0;
		busWrite <= 1'b0;
		latency = 1;
		acked = 1'b0;
		readData = '0;
		while (!acked && latency <= AckTimeout)
		begin
			@(negedge clock);
			if (busOk)
			begin
				acked = 1'b1;
				readData = busReadData;
			end
			else
				latency++;
		end
		if (acked)
			checkEqual("ack latency", latency, 2);
	endtask

	task automatic writeWord(input logic [31:0] addr, input logic [31:0] data);
		logic [31:0] ignored;
		logic acked;
		busAccess(1'b1, addr, data, ignored, acked);
		assert (acked)
		else
		begin
			$display("no acknowledge for write to address %h", addr);
			errorCount++;
		end
	endtask

	task automatic readWord(input logic [31:0] addr, output logic [31:0] data);
		logic acked;
		busAccess(1'b0, addr, '0, data, acked);
		assert (acked)
		else
		begin
			$display("no acknowledge for read from address %h", addr);
			errorCount++;
		end
	endtask

	task automatic fillMemory(input logic [31:0] word);
		for (int i = 0; i < MemWords; i++)
			writeWord(sampleAddr(i), word);
	endtask

	task automatic countOnes(input int cycles, output int ones);
		ones = 0;
		repeat (cycles)
		begin
			@(negedge clock);
			if (pwmOut === 1'b1)
				ones++;
		end
	endtask

	// over 2^16 cycles the number of ones equals the duty word
	task automatic checkDensity(input logic [15:0] duty);
		int ones;
		repeat (64) @(negedge clock);
		checkEqual("pwmEnable", pwmEnable, 1);
		countOnes(65536, ones);
		checkNear("pwmOut ones", ones, duty, 2);
	endtask

	task automatic runByteTest(input logic compand);
		logic [7:0] sample8;
		logic [11:0] value12;
		sample8 = $random(seed);
		// output off while refilling
		writeWord(regAddr(pcmAudioPkg::RegControl), Rate8);
		fillMemory({4{sample8}});
		writeWord(regAddr(pcmAudioPkg::RegControl), OutOn | Rate8 | (compand ? Compand : 0));
		if (compand)
			value12 = decodeCompanded(sample8);
		else
			value12 = {~sample8[7], sample8[6:0], 4'h0};
		checkDensity(dutyForLevel(levelFrom12(value12)));
	endtask

	task automatic reportTest(input string name);
		testCount++;
		if (errorCount == errorsAtStart)
			$display("test %s: passed", name);
		else
		begin
			failedTests++;
			$display("test %s: failed with %0d errors", name, errorCount - errorsAtStart);
		end
		errorsAtStart = errorCount;
	endtask

	task automatic runBeeperTest();
		int windows [4];
		int lowOnes;
		int highOnes;
		logic startLow;
		lowOnes = (int'(clipMixed(pcmAudioPkg::BeepLow)) * 64) / 65536;
		highOnes = (int'(clipMixed(pcmAudioPkg::BeepHigh)) * 64) / 65536;
		// half period of 256 cycles with windows inside each half
		writeWord(regAddr(pcmAudioPkg::RegBeep), 32'd255);
		repeat (69) @(negedge clock);
		for (int k = 0; k < 4; k++)
		begin
			countOnes(64, windows[k]);
			repeat (192) @(negedge clock);
		end
		// start phase of the square wave is free
		// so the two levels only have to alternate
		startLow = (windows[0] <= lowOnes + 2) && (windows[0] >= lowOnes - 2);
		for (int k = 0; k < 4; k++)
			checkNear("pwmOut window ones", windows[k],
				((k % 2 == 0) == startLow) ? lowOnes : highOnes, 2);
		writeWord(regAddr(pcmAudioPkg::RegBeep), 32'd0);
		checkDensity(dutyForLevel(levelFrom12({~sample16[15], sample16[14:4]})));
	endtask

	initial
	begin
		logic [31:0] value;
		logic [31:0] readData;
		logic [31:0] posFirst;
		logic [31:0] posSecond;
		logic acked;
		int steps;
		int span;
		busAddr = '0;
		busWriteData = '0;
		busRead = 1'b0;
		busWrite = 1'b0;
		tick1Mhz = 1'b1;
		reset = 1'b1;
		repeat (16) @(posedge clock);
		reset <= 1'b0;

		@(negedge clock);
		checkEqual("busOk", busOk, 0);
		checkEqual("pwmEnable", pwmEnable, 0);
		checkEqual("pwmOut", pwmOut, 1);
		readWord(regAddr(pcmAudioPkg::RegControl), readData);
		checkEqual("control", readData, 0);
		readWord(regAddr(pcmAudioPkg::RegBeep), readData);
		checkEqual("beep", readData, 0);
		reportTest("after reset");

		repeat (4)
		begin
			// output stays off while memory is unwritten
			value = $random(seed);
			value[pcmAudioPkg::OutEnableBit] = 1'b0;
			writeWord(regAddr(pcmAudioPkg::RegControl), value);
			readWord(regAddr(pcmAudioPkg::RegControl), readData);
			checkEqual("control", readData, value);
			value = $random(seed);
			writeWord(regAddr(pcmAudioPkg::RegBeep), value);
			readWord(regAddr(pcmAudioPkg::RegBeep), readData);
			checkEqual("beep", readData, value);
		end
		writeWord(regAddr(pcmAudioPkg::RegBeep), 32'd0);
		readWord(regAddr(6'h05), readData);
		checkEqual("unmapped offset", readData, 0);
		busAccess(1'b0, 32'h000A_F000, '0, readData, acked);
		assert (!acked)
		else
		begin
			$display("acknowledge returned for an address outside the device");
			errorCount++;
		end
		reportTest("register access");

		// let a slow divider count from the old rate drain first
		writeWord(regAddr(pcmAudioPkg::RegControl), Rate8);
		repeat (6400) @(posedge clock);
		span = (pcmAudioPkg::RateDivTable[8] + 1) * 16;
		readWord(regAddr(pcmAudioPkg::RegPosition), posFirst);
		repeat (span) @(posedge clock);
		readWord(regAddr(pcmAudioPkg::RegPosition), posSecond);
		steps = int'((posSecond - posFirst) & ((32'd1 << PosWidth) - 1));
		checkNear("position steps", steps, span / (pcmAudioPkg::RateDivTable[8] + 1), 1);
		reportTest("position rate");

		sample16 = $random(seed);
		fillMemory({sample16, sample16});
		writeWord(regAddr(pcmAudioPkg::RegControl), OutOn | Fmt16 | Rate8);
		checkDensity(dutyForLevel(levelFrom12({~sample16[15], sample16[14:4]})));
		reportTest("16-bit linear");

		runBeeperTest();
		reportTest("beeper");

		runByteTest(1'b0);
		reportTest("8-bit linear");
		runByteTest(1'b1);
		reportTest("8-bit companded");

		$display("tests %0d, failed %0d, errors %0d", testCount, failedTests, errorCount);
		if (errorCount == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// overall bound on the run
	initial
	begin
		repeat (WatchdogCycles) @(posedge clock);
		$display("simulation timed out before all tests finished");
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
pcmAudioPkg.sv
pcmBusRegs.sv
pcmSampleClock.sv
pcmSampleMem.sv
pcmDecode.sv
pcmBeeper.sv
pcmOutputStage.sv
pcmAudio.sv
pcmAudioTb.sv
